// ==== Makefile ====
# Verilator simulation of the hazard-control testbench

VERILATOR ?= verilator
TOP ?= hazardTb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert -j 0
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# The simulator's exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
src/hazardPkg.sv
src/stageTrack.sv
src/bypassSel.sv
src/stallCtrl.sv
src/hazardTop.sv
dv/hazardCtrl_properties.sv
dv/hazardTb.sv

// ==== dv/hazardCtrl_properties.sv ====
`timescale 1ns/1ps

module hazardCtrl_properties import hazardPkg::*; (
	input logic clk,
	input logic rst_sign,
	input idInfo_t id,
	input pipeState_t pipe,
	input logic flush,
	input pipeWr_t wr,
	input fwdSels_t fwd,
	input logic dcacheStall,
	input logic isStall
);

	stallFollowsPc: assert property (@(posedge clk) disable iff (rst_sign)
		isStall == !wr.pcWr)
		else $error("isStall is not the inverse of pcWr");

	// Vector redirect always refetches
	redirectFetches: assert property (@(posedge clk) disable iff (rst_sign)
		wr.pcSel |-> wr.fetchEn)
		else $error("pcSel high with fetchEn low");

	cacheFreeze: assert property (@(posedge clk) disable iff (rst_sign)
		(dcacheStall && !flush) |-> !(wr.ifIdWr || wr.idExWr || wr.exMem1Wr
			|| wr.mem1Mem2Wr || wr.mem2WbWr))
		else $error("Stage enable high during a cache stall");

	zeroNoForward: assert property (@(posedge clk) disable iff (rst_sign)
		(pipe.ex.rs != '0 || fwd.exRs == FWD_NONE) && (pipe.ex.rt != '0 || fwd.exRt == FWD_NONE)
		&& (id.rs != '0 || fwd.idRs == FWD_NONE) && (id.rt != '0 || fwd.idRt == FWD_NONE))
		else $error("Register zero source was forwarded");

endmodule

// ==== dv/hazardTb.sv ====
`timescale 1ns/1ps

module hazardTb import hazardPkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam logic [7:0] RESET_WR = 8'h1f; // Front held and back open with vector redirect

	typedef struct packed {
		idInfo_t id;
		cacheStat_t cache;
		logic mulBusy;
		logic flush;
		fwdSels_t fwd;
		pipeWr_t wr;
	} vector_t;

	logic clk = 1'b0;
	logic rst_sign;
	idInfo_t id;
	cacheStat_t cache;
	logic mulBusy;
	logic flush;
	fwdSels_t fwd;
	pipeWr_t wr;
	logic dcacheStall;
	logic isStall;

	string names[$];
	vector_t vecs[$];
	int cycles = 0;
	int limit = 0;

	logic exLoad;
	logic mem1Load;
	logic stallExp;

	always #2 clk = ~clk;

	hazardTop UUT (
		.clk(clk),
		.rst_sign(rst_sign),
		.id(id),
		.cache(cache),
		.mulBusy(mulBusy),
		.flush(flush),
		.fwd(fwd),
		.wr(wr),
		.dcacheStall(dcacheStall),
		.isStall(isStall)
	);

	bind hazardTop hazardCtrl_properties uProps (
		.clk(clk),
		.rst_sign(rst_sign),
		.id(id),
		.pipe(pipe),
		.flush(flush),
		.wr(wr),
		.fwd(fwd),
		.dcacheStall(dcacheStall),
		.isStall(isStall)
	);

	task automatic checkVal(input string test, input string what,
		input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: %s expected %h actual %h", test, what, expected, actual);
			$display("Something failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Loads in EX and MEM1, moved by the expected enables
	task automatic trackLoads(input vector_t v);
		if (v.wr.pcSel) begin
			exLoad = 1'b0;
			mem1Load = 1'b0;
		end else begin
			if (v.wr.exMem1Wr) begin
				mem1Load = exLoad;
			end
			if (v.wr.idExWr) begin
				exLoad = v.wr.ifIdWr && v.id.memRead; // Bubble on a data stall
			end
		end
	endtask

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		string nm;
		logic [4:0] rs, rt, rd, op;
		logic rw, mr, c0, br, iOk, dOk, aOk, mb, fl;
		logic [31:0] pc;
		logic [7:0] fwdExp, wrExp;
		vector_t v;
		fd = $fopen("dv/hazard_testdata.txt", "r");
		if (fd == 0) begin
			$display("Something failed");
			$fatal(1, "Cannot open dv/hazard_testdata.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#") continue; // Column notes and blank lines
			n = $sscanf(line, "%s %d %d %d %b %b %b %b %h %h %b %b %b %b %b %h %h",
				nm, rs, rt, rd, rw, mr, c0, br, op, pc, iOk, dOk, aOk, mb, fl, fwdExp, wrExp);
			if (n != 17) begin
				$display("Something failed");
				$fatal(1, "Data file line has %0d fields instead of 17", n);
			end
			v.id = '{rs: rs, rt: rt, rd: rd, regWrite: rw, memRead: mr, cp0Read: c0,
				branch: br, aluOp: aluOp_t'(op), pc: pc};
			v.cache = '{iDataOk: iOk, dDataOk: dOk, dAddrOk: aOk};
			v.mulBusy = mb;
			v.flush = fl;
			v.fwd = fwdExp;
			v.wr = wrExp;
			names.push_back(nm);
			vecs.push_back(v);
		end
		$fclose(fd);
		if (vecs.size() == 0) begin
			$display("Something failed");
			$fatal(1, "Data file holds no vectors");
		end
	endtask

	// Run length bound
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("Something failed");
			$fatal(1, "Timeout after %0d cycles", cycles);
		end
	end

	initial begin
		rst_sign = 1'b1;
		id = '0;
		cache = '1;
		mulBusy = 1'b0;
		flush = 1'b0;
		exLoad = 1'b0;
		mem1Load = 1'b0;
		loadVectors();
		limit = vecs.size() + RESET_CYCLES + 20;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			checkVal("reset", "wr", RESET_WR, wr);
			checkVal("reset", "isStall", 8'h01, {7'b0, isStall});
		end
		for (int i = 0; i < vecs.size(); i++) begin
			@(posedge clk);
			rst_sign <= 1'b0;
			id <= vecs[i].id; // Held descriptor repeats in the file on stalls
			cache <= vecs[i].cache;
			mulBusy <= vecs[i].mulBusy;
			flush <= vecs[i].flush;
			@(negedge clk);
			checkVal(names[i], "fwd", vecs[i].fwd, fwd);
			checkVal(names[i], "wr", vecs[i].wr, wr);
			checkVal(names[i], "isStall", {7'b0, !vecs[i].wr.pcWr}, {7'b0, isStall});
			stallExp = !vecs[i].cache.iDataOk
				|| (mem1Load && !(vecs[i].cache.dDataOk && vecs[i].cache.dAddrOk));
			checkVal(names[i], "dcacheStall", {7'b0, stallExp}, {7'b0, dcacheStall});
			trackLoads(vecs[i]);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== dv/hazard_testdata.txt ====
# name rs rt rd regWrite memRead cp0Read branch aluOp(hex) pc(hex) iDataOk dDataOk dAddrOk mulBusy flush
# expFwd(hex exRs,exRt,idRs,idRt) expWr(hex fetchEn,pcWr,ifIdWr,idExWr,exMem1Wr,mem1Mem2Wr,mem2WbWr,pcSel)
fwdA1 1 2 3 1 0 0 0 00 00400000 1 1 1 0 0 00 fe
fwdA2 1 2 3 1 0 0 0 00 00400004 1 1 1 0 0 00 fe
fwdA3 1 2 3 1 0 0 0 00 00400008 1 1 1 0 0 00 fe
fwdA4 3 0 6 1 0 0 0 00 0040000c 1 1 1 0 0 00 fe
fwdMem1 0 3 7 1 0 0 0 00 00400010 1 1 1 0 0 40 fe
fwdMem2 3 3 0 1 0 0 0 00 00400014 1 1 1 0 0 20 fe
fwdWb 0 0 9 1 0 0 0 00 00400018 1 1 1 0 0 f0 fe
fwdZero 0 0 0 0 0 0 0 00 0040001c 1 1 1 0 0 00 fe
ldUse1 1 10 10 1 1 0 0 00 00400020 1 1 1 0 0 00 fe
ldUse2 10 2 11 1 0 0 0 00 00400024 1 1 1 0 0 00 1e
ldUse3 10 2 11 1 0 0 0 00 00400024 1 1 1 0 0 00 1e
ldUse4 10 2 11 1 0 0 0 00 00400024 1 1 1 0 0 00 fe
ldUse5 0 0 0 0 0 0 0 00 00400028 1 1 1 0 0 c0 fe
br1 1 2 12 1 0 0 0 00 0040002c 1 1 1 0 0 00 fe
br2 12 11 0 0 0 0 1 00 00400030 1 1 1 0 0 02 1e
br3 12 11 0 0 0 0 1 00 00400030 1 1 1 0 0 04 fe
movn1 1 12 13 1 0 0 0 0b 00400034 1 1 1 0 0 82 fe
dc1 1 14 14 1 1 0 0 00 00400038 1 1 1 0 0 30 fe
dc2 0 0 0 0 0 0 0 00 0040003c 1 1 1 0 0 00 fe
dc3 0 0 0 0 0 0 0 00 00400040 1 0 1 0 0 00 00
dc4 0 0 0 0 0 0 0 00 00400040 1 1 1 0 0 00 fe
ic1 0 0 0 0 0 0 0 00 00400044 0 1 1 0 0 00 00
ic2 0 0 0 0 0 0 0 00 00400044 1 1 1 0 0 00 fe
mul1 1 2 0 0 0 0 0 08 00400048 1 1 1 1 0 00 00
mul2 1 2 0 0 0 0 0 08 00400048 1 1 1 0 0 00 fe
fl1 1 2 15 1 0 0 0 00 0040004c 1 1 1 0 0 00 fe
fl2 1 16 16 1 1 0 0 00 00400050 1 1 1 0 0 00 fe
fl3 15 1 17 1 0 0 0 00 00400054 1 1 1 0 0 00 fe
fl4 0 0 0 0 0 0 0 00 00400058 1 0 1 0 1 80 f9
fl5 16 17 0 0 0 0 1 00 00400100 1 1 1 0 0 00 fe
fl6 0 0 0 0 0 0 0 00 00400104 1 1 1 0 1 00 ff
fl7 0 0 0 0 0 0 0 00 00400100 1 1 1 0 0 00 fe
brLd1 1 18 18 1 1 0 0 00 00400104 1 1 1 0 0 00 fe
brLd2 0 0 0 0 0 0 0 00 00400108 1 1 1 0 0 00 fe
brLd3 18 0 0 0 0 0 1 00 0040010c 1 1 1 0 0 04 1e
brLd4 18 0 0 0 0 0 1 00 0040010c 1 1 1 0 0 08 1e
brLd5 18 0 0 0 0 0 1 00 0040010c 1 1 1 0 0 00 fe
da1 1 19 19 1 1 0 0 00 00400110 1 1 1 0 0 00 fe
da2 0 0 0 0 0 0 0 00 00400114 1 1 1 0 0 00 fe
da3 0 0 0 0 0 0 0 00 00400118 1 1 0 0 0 00 00
da4 0 0 0 0 0 0 0 00 00400118 1 1 1 0 0 00 fe

// ==== src/bypassSel.sv ====
`timescale 1ns/1ps

module bypassSel import hazardPkg::*; (
	input idInfo_t id,
	input pipeState_t pipe,
	output fwdSels_t fwd
);

	logic idRsUse;
	logic idRtUse;

	// Stage writes register r and r is not $0
	function automatic logic hits(input stageInfo_t s, input logic [REG_W-1:0] r);
		return s.valid && s.regWrite && (s.rd != REG_ZERO) && (s.rd == r);
	endfunction

	// EX operands, youngest producer first
	function automatic fwdSel_t exSel(input logic [REG_W-1:0] r, input pipeState_t p);
		fwdSel_t sel;
		if (hits(p.mem1, r)) begin
			sel = FWD_MEM1;
		end else if (hits(p.mem2, r)) begin
			sel = FWD_MEM2;
		end else if (hits(p.wb, r)) begin
			sel = FWD_WB;
		end else begin
			sel = FWD_NONE;
		end
		return sel;
	endfunction

	// ID operands only reach back to MEM1 and MEM2
	function automatic fwdSel_t idSel(
		input logic en,
		input logic [REG_W-1:0] r,
		input pipeState_t p
	);
		fwdSel_t sel;
		if (en && hits(p.mem1, r)) begin
			sel = FWD_MEM1;
		end else if (en && hits(p.mem2, r)) begin
			sel = FWD_MEM2;
		end else begin
			sel = FWD_NONE;
		end
		return sel;
	endfunction

	assign idRsUse = id.branch;
	assign idRtUse = id.branch || (id.aluOp == ALU_MOVC); // movn/movz test rt early

	always_comb begin
		fwd.exRs = exSel(pipe.ex.rs, pipe);
		fwd.exRt = exSel(pipe.ex.rt, pipe);
		fwd.idRs = idSel(idRsUse, id.rs, pipe);
		fwd.idRt = idSel(idRtUse, id.rt, pipe);
	end

endmodule

// ==== src/hazardPkg.sv ====
package hazardPkg;

	localparam int REG_W = 5;
	localparam int PC_W = 32;

	// Register index zero never forwards
	localparam logic [REG_W-1:0] REG_ZERO = '0;

	typedef enum logic [4:0] {
		ALU_OTHER = 5'b00000,
		ALU_MUL = 5'b01000, // Waits on the multiplier
		ALU_MOVC = 5'b01011 // movn/movz read rt in ID
	} aluOp_t;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_MEM1 = 2'b01,
		FWD_MEM2 = 2'b10,
		FWD_WB = 2'b11
	} fwdSel_t;

	typedef struct packed {
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] rd; // Destination after the rd/rt choice
		logic regWrite;
		logic memRead;
		logic cp0Read;
		logic branch;
		aluOp_t aluOp;
		logic [PC_W-1:0] pc;
	} idInfo_t;

	typedef struct packed {
		logic valid;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rt;
		logic regWrite;
		logic memRead;
		logic cp0Read;
		logic [PC_W-1:0] pc;
	} stageInfo_t;

	typedef struct packed {
		stageInfo_t ex;
		stageInfo_t mem1;
		stageInfo_t mem2;
		stageInfo_t wb;
	} pipeState_t;

	typedef struct packed {
		logic iDataOk;
		logic dDataOk;
		logic dAddrOk;
	} cacheStat_t;

	typedef struct packed {
		logic fetchEn;
		logic pcWr;
		logic ifIdWr;
		logic idExWr;
		logic exMem1Wr;
		logic mem1Mem2Wr;
		logic mem2WbWr;
		logic pcSel; // Redirect to exception vector
	} pipeWr_t;

	typedef struct packed {
		fwdSel_t exRs;
		fwdSel_t exRt;
		fwdSel_t idRs;
		fwdSel_t idRt;
	} fwdSels_t;

endpackage

// ==== src/hazardTop.sv ====
`timescale 1ns/1ps

module hazardTop import hazardPkg::*; (
	input logic clk,
	input logic rst_sign,
	input idInfo_t id,
	input cacheStat_t cache,
	input logic mulBusy,
	input logic flush, // Exception or eret from MEM1
	output fwdSels_t fwd,
	output pipeWr_t wr,
	output logic dcacheStall,
	output logic isStall
);

	pipeState_t pipe;

	// Destination shadow of EX through WB
	stageTrack uTrack (
		.clk(clk),
		.rst_sign(rst_sign),
		.id(id),
		.wr(wr),
		.pipe(pipe)
	);

	bypassSel uBypass (
		.id(id),
		.pipe(pipe),
		.fwd(fwd)
	);

	stallCtrl uStall (
		.rst_sign(rst_sign),
		.id(id),
		.pipe(pipe),
		.cache(cache),
		.mulBusy(mulBusy),
		.flush(flush),
		.wr(wr),
		.dcacheStall(dcacheStall),
		.isStall(isStall)
	);

endmodule

// ==== src/stageTrack.sv ====
`timescale 1ns/1ps

module stageTrack import hazardPkg::*; (
	input logic clk,
	input logic rst_sign,
	input idInfo_t id,
	input pipeWr_t wr,
	output pipeState_t pipe
);

	stageInfo_t exReg;
	stageInfo_t mem1Reg;
	stageInfo_t mem2Reg;
	stageInfo_t wbReg;
	stageInfo_t idStage;
	stageInfo_t bubble;

	// Descriptor of the instruction leaving ID
	always_comb begin
		idStage.valid = 1'b1;
		idStage.rs = id.rs;
		idStage.rd = id.rd;
		idStage.rt = id.rt;
		idStage.regWrite = id.regWrite;
		idStage.memRead = id.memRead;
		idStage.cp0Read = id.cp0Read;
		idStage.pc = id.pc;
	end

	// Empty slot, nothing written and nothing loaded
	always_comb begin
		bubble = '0;
		bubble.pc = id.pc;
	end

	// EX takes a bubble when ID holds back, cleared on a flush
	always_ff @(posedge clk) begin
		if (rst_sign) begin
			exReg <= '0;
		end else if (wr.pcSel) begin
			exReg <= bubble;
		end else if (wr.idExWr) begin
			exReg <= wr.ifIdWr ? idStage : bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			mem1Reg <= '0;
		end else if (wr.pcSel) begin
			mem1Reg <= bubble; // Faulting instruction dropped
		end else if (wr.exMem1Wr) begin
			mem1Reg <= exReg;
		end
	end

	// Older stages keep draining under their own enables
	always_ff @(posedge clk) begin
		if (rst_sign) begin
			mem2Reg <= '0;
		end else if (wr.mem1Mem2Wr) begin
			mem2Reg <= mem1Reg;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			wbReg <= '0;
		end else if (wr.mem2WbWr) begin
			wbReg <= mem2Reg;
		end
	end

	always_comb begin
		pipe.ex = exReg;
		pipe.mem1 = mem1Reg;
		pipe.mem2 = mem2Reg;
		pipe.wb = wbReg;
	end

endmodule

// ==== src/stallCtrl.sv ====
`timescale 1ns/1ps

module stallCtrl import hazardPkg::*; (
	input logic rst_sign,
	input idInfo_t id,
	input pipeState_t pipe,
	input cacheStat_t cache,
	input logic mulBusy,
	input logic flush,
	output pipeWr_t wr,
	output logic dcacheStall,
	output logic isStall
);

	logic mem1Load;
	logic dataOk;
	logic earlyRead;
	logic mulStall;
	logic exLoadUse;
	logic mem1LoadUse;
	logic mem2LoadUse;
	logic exEarlyUse;
	logic dataStall;

	// Data cache request sits in MEM1
	assign mem1Load = pipe.mem1.valid && pipe.mem1.memRead;
	assign dataOk = cache.dDataOk || !mem1Load;

	assign dcacheStall = !cache.iDataOk
		|| (mem1Load && !cache.dDataOk)
		|| (mem1Load && !cache.dAddrOk);

	assign earlyRead = id.branch || (id.aluOp == ALU_MOVC);
	assign mulStall = (id.aluOp == ALU_MUL) && mulBusy;

	// Load or mfc0 results not ready for ID
	assign exLoadUse = pipe.ex.valid
		&& (pipe.ex.memRead || pipe.ex.cp0Read)
		&& ((pipe.ex.rt == id.rs) || (pipe.ex.rt == id.rt));
	assign mem1LoadUse = pipe.mem1.valid
		&& (pipe.mem1.memRead || pipe.mem1.cp0Read)
		&& ((pipe.mem1.rt == id.rs) || (pipe.mem1.rt == id.rt));
	assign mem2LoadUse = earlyRead && pipe.mem2.valid
		&& (pipe.mem2.memRead || pipe.mem2.cp0Read)
		&& ((pipe.mem2.rt == id.rs) || (pipe.mem2.rt == id.rt));
	// Branch compare cannot take an EX result
	assign exEarlyUse = earlyRead && pipe.ex.valid && pipe.ex.regWrite
		&& ((pipe.ex.rd == id.rs) || (pipe.ex.rd == id.rt));

	assign dataStall = exLoadUse || mem1LoadUse || mem2LoadUse || exEarlyUse;

	always_comb begin
		if (rst_sign) begin
			wr = '{fetchEn: 1'b0, pcWr: 1'b0, ifIdWr: 1'b0,
				idExWr: 1'b1, exMem1Wr: 1'b1, mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1,
				pcSel: 1'b1};
		end else if (flush) begin
			// Exception or eret wins over any pending stall
			wr = '{fetchEn: 1'b1, pcWr: 1'b1, ifIdWr: 1'b1,
				idExWr: 1'b1, exMem1Wr: 1'b1, mem1Mem2Wr: dataOk, mem2WbWr: dataOk,
				pcSel: 1'b1};
		end else if (dcacheStall) begin
			wr = '{fetchEn: 1'b0, pcWr: 1'b0, ifIdWr: 1'b0,
				idExWr: 1'b0, exMem1Wr: 1'b0, mem1Mem2Wr: 1'b0, mem2WbWr: 1'b0,
				pcSel: 1'b0};
		end else if (mulStall) begin
			wr = '{fetchEn: 1'b0, pcWr: 1'b0, ifIdWr: 1'b0,
				idExWr: 1'b0, exMem1Wr: 1'b0, mem1Mem2Wr: 1'b0, mem2WbWr: 1'b0,
				pcSel: 1'b0};
		end else if (dataStall) begin
			// Hold IF/ID, bubble goes into EX
			wr = '{fetchEn: 1'b0, pcWr: 1'b0, ifIdWr: 1'b0,
				idExWr: 1'b1, exMem1Wr: 1'b1, mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1,
				pcSel: 1'b0};
		end else begin
			wr = '{fetchEn: 1'b1, pcWr: 1'b1, ifIdWr: 1'b1,
				idExWr: 1'b1, exMem1Wr: 1'b1, mem1Mem2Wr: 1'b1, mem2WbWr: 1'b1,
				pcSel: 1'b0};
		end
	end

	assign isStall = !wr.pcWr;

endmodule
